// ==== source/memory_defs.svh ====
`ifndef MEMORY_DEFS_SVH
`define MEMORY_DEFS_SVH

// ==========================================================================
// memory geometry
// ==========================================================================

`define MEM_ADDR_WIDTH      11  // group, bank, subarray, row.
`define MEM_DATA_WIDTH      8   // one byte per word.

`define MEM_GROUPS          2
`define MEM_BANKS_PER_GROUP 2
`define MEM_SUBARRAYS       4   // subarrays in one bank.
`define MEM_ROWS            128 // rows in one subarray.

// request sampling edge to readResult and writeDropped.
`define MEM_READ_LATENCY    2

`endif

// ==== source/memPkg.sv ====
`include "memory_defs.svh"

package memPkg;

    // ======================================================================
    // address fields
    // ======================================================================

    typedef logic [`MEM_DATA_WIDTH-1:0]        dataT;
    typedef logic [$clog2(`MEM_ROWS)-1:0]      rowT;
    typedef logic [$clog2(`MEM_SUBARRAYS)-1:0] subIdxT;

    typedef struct packed {
        logic   group;    // low or high 1024 words.
        logic   bank;     // bank within the group.
        subIdxT subarray;
        rowT    row;
    } memAddrT;

    // ======================================================================
    // requests and results
    // ======================================================================

    typedef struct packed {
        logic    valid;
        memAddrT addr;
    } readReqT;

    typedef struct packed {
        logic    valid;
        memAddrT addr;
        dataT    data;
    } writeReqT;

    typedef struct packed {
        logic valid;
        dataT data; // zero unless valid.
    } readResultT;

endpackage

// ==== source/subArray.sv ====
`include "memory_defs.svh"

module subArray #(
    parameter type cellT = memPkg::dataT
) (
    input  logic        clk,
    input  logic        readEn,
    input  logic        writeEn,
    input  memPkg::rowT row,
    input  cellT        writeData,
    output cellT        readData,
    output logic        readValid
);

    cellT cells [`MEM_ROWS];

    // ======================================================================
    // single port access
    // ======================================================================

    // a read owns the port, so a write in the same cycle is lost.
    always_ff @(posedge clk) begin
        if (readEn) begin
            readData <= cells[row];
        end else begin
            readData <= '0; // idle output reads as zero.
            if (writeEn) begin
                cells[row] <= writeData;
            end
        end
    end

    always_ff @(posedge clk) begin
        readValid <= readEn; // tracks readData.
    end

    // ======================================================================
    // checks
    // ======================================================================

    enablesKnown: assert property (
        @(posedge clk) !$isunknown({readEn, writeEn})
    ) else $error("subArray enable is unknown");

endmodule

// ==== source/memoryBank.sv ====
`include "memory_defs.svh"

module memoryBank (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::readReqT    readReq,
    input  memPkg::writeReqT   writeReq,
    output memPkg::readResultT readResult,
    output logic               writeDropped
);

    import memPkg::*;

    logic [`MEM_SUBARRAYS-1:0] readHit;
    logic [`MEM_SUBARRAYS-1:0] writeHit;
    logic [`MEM_SUBARRAYS-1:0] subValid;
    rowT                       subRow [`MEM_SUBARRAYS];
    dataT                      subData [`MEM_SUBARRAYS];
    logic                      conflict;
    logic                      readValidQ;
    subIdxT                    readSubQ;

    // ======================================================================
    // steering
    // ======================================================================

    // a write to the subarray being read is dropped.
    assign conflict = readReq.valid && writeReq.valid &&
                      (readReq.addr.subarray == writeReq.addr.subarray);

    for (genvar i = 0; i < `MEM_SUBARRAYS; i++) begin : gSub
        assign readHit[i]  = readReq.valid && (readReq.addr.subarray == subIdxT'(i));
        assign writeHit[i] = writeReq.valid && !conflict &&
                             (writeReq.addr.subarray == subIdxT'(i));

        // the read row wins its subarray.
        assign subRow[i] = readHit[i] ? readReq.addr.row : writeReq.addr.row;

        subArray #(
            .cellT(dataT)
        ) u_sub (
            .clk      (clk),
            .readEn   (readHit[i]),
            .writeEn  (writeHit[i]),
            .row      (subRow[i]),
            .writeData(writeReq.data),
            .readData (subData[i]),
            .readValid(subValid[i])
        );
    end

    // ======================================================================
    // result
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            readValidQ   <= 1'b0;
            readSubQ     <= '0;
            writeDropped <= 1'b0;
        end else begin
            readValidQ   <= readReq.valid;
            readSubQ     <= readReq.addr.subarray; // read source.
            writeDropped <= conflict;
        end
    end

    always_comb begin
        readResult.valid = readValidQ;
        readResult.data  = readValidQ ? subData[readSubQ] : '0;
    end

    subReadOneHot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(subValid)
    ) else $error("more than one subarray returned read data");

endmodule

// ==== source/bankGroup.sv ====
`include "memory_defs.svh"

module bankGroup #(
    parameter logic GroupId = 1'b0
) (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::readReqT    readReq,
    input  memPkg::writeReqT   writeReq,
    output memPkg::readResultT readResult,
    output logic               writeDropped
);

    import memPkg::*;

    readReqT                         bankRead [`MEM_BANKS_PER_GROUP];
    writeReqT                        bankWrite [`MEM_BANKS_PER_GROUP];
    readResultT                      bankResult [`MEM_BANKS_PER_GROUP];
    logic [`MEM_BANKS_PER_GROUP-1:0] bankDropped;
    logic                            groupRead;
    logic                            groupWrite;
    logic                            bankQ;

    // ======================================================================
    // bank decode
    // ======================================================================

    assign groupRead  = readReq.valid && (readReq.addr.group == GroupId);
    assign groupWrite = writeReq.valid && (writeReq.addr.group == GroupId);

    for (genvar b = 0; b < `MEM_BANKS_PER_GROUP; b++) begin : gBank
        assign bankRead[b] = '{
            valid: groupRead && (readReq.addr.bank == 1'(b)),
            addr:  readReq.addr
        };
        assign bankWrite[b] = '{
            valid: groupWrite && (writeReq.addr.bank == 1'(b)),
            addr:  writeReq.addr,
            data:  writeReq.data
        };

        memoryBank u_bank (
            .clk         (clk),
            .reset       (reset),
            .readReq     (bankRead[b]),
            .writeReq    (bankWrite[b]),
            .readResult  (bankResult[b]),
            .writeDropped(bankDropped[b])
        );
    end

    // ======================================================================
    // output select
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            bankQ <= 1'b0;
        end else if (groupRead) begin
            bankQ <= readReq.addr.bank; // lines up with bank result.
        end
    end

    assign readResult   = bankResult[bankQ];
    assign writeDropped = |bankDropped;

endmodule

// ==== source/readMerge.sv ====
`include "memory_defs.svh"

module readMerge (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::readReqT    readReq,
    input  memPkg::readResultT groupResult0,
    input  memPkg::readResultT groupResult1,
    input  logic               groupDropped0,
    input  logic               groupDropped1,
    output memPkg::readResultT readResult,
    output logic               writeDropped
);

    import memPkg::*;

    logic       groupQ;
    readResultT selected;

    // ======================================================================
    // group select
    // ======================================================================

    always_ff @(posedge clk) begin
        if (reset) begin
            groupQ <= 1'b0;
        end else if (readReq.valid) begin
            groupQ <= readReq.addr.group; // matches group result timing.
        end
    end

    assign selected = groupQ ? groupResult1 : groupResult0;

    always_ff @(posedge clk) begin
        if (reset) begin
            readResult   <= '0;
            writeDropped <= 1'b0;
        end else begin
            readResult   <= selected;
            writeDropped <= groupDropped0 | groupDropped1;
        end
    end

    // ======================================================================
    // checks
    // ======================================================================

    readReturns: assert property (
        @(posedge clk) disable iff (reset)
        readReq.valid |-> ##`MEM_READ_LATENCY readResult.valid
    ) else $error("read request did not return data");

endmodule

// ==== source/multiBankMemory.sv ====
`include "memory_defs.svh"

module multiBankMemory (
    input  logic               clk,
    input  logic               reset,
    input  memPkg::readReqT    readReq,
    input  memPkg::writeReqT   writeReq,
    output memPkg::readResultT readResult,
    output logic               writeDropped
);

    import memPkg::*;

    readResultT groupResult0;
    readResultT groupResult1;
    logic       groupDropped0;
    logic       groupDropped1;

    // geometry must match the address struct.
    if ($bits(memAddrT) != `MEM_ADDR_WIDTH) begin : gAddrCheck
        $error("memAddrT width differs from MEM_ADDR_WIDTH");
    end
    if (`MEM_GROUPS != 2) begin : gGroupCheck
        $error("the group bit supports exactly two bank groups");
    end

    // ======================================================================
    // bank groups
    // ======================================================================

    bankGroup #(
        .GroupId(1'b0)
    ) u_group0 (
        .clk         (clk),
        .reset       (reset),
        .readReq     (readReq),
        .writeReq    (writeReq),
        .readResult  (groupResult0),
        .writeDropped(groupDropped0)
    );

    bankGroup #(
        .GroupId(1'b1)
    ) u_group1 (
        .clk         (clk),
        .reset       (reset),
        .readReq     (readReq),
        .writeReq    (writeReq),
        .readResult  (groupResult1),
        .writeDropped(groupDropped1)
    );

    // ======================================================================
    // merge
    // ======================================================================

    readMerge u_merge (
        .clk          (clk),
        .reset        (reset),
        .readReq      (readReq),
        .groupResult0 (groupResult0),
        .groupResult1 (groupResult1),
        .groupDropped0(groupDropped0),
        .groupDropped1(groupDropped1),
        .readResult   (readResult),
        .writeDropped (writeDropped)
    );

endmodule

// ==== testbench/memoryChecker.sv ====
module memoryChecker #(
    parameter int NameBits = 192
) (
    input  logic                clk,
    input  logic                reset,
    input  memPkg::readReqT     readReq,
    input  memPkg::writeReqT    writeReq,
    input  memPkg::readResultT  readResult,
    input  logic                writeDropped,
    input  logic                expActive,
    input  logic [NameBits-1:0] expName,
    input  memPkg::readResultT  expResult,
    input  logic                expDrop,
    input  logic                done,
    output logic                reported,
    output int                  failedTests
);

    import memPkg::*;

    logic [NameBits-1:0] curName;
    int                  testChecks;
    int                  testErrors;
    int                  testsRun;
    int                  badTests;
    int                  readsIssued;
    int                  readsReturned;
    int                  writesSeen;

    initial begin
        reported      = 1'b0;
        failedTests   = 0;
        curName       = '0;
        testChecks    = 0;
        testErrors    = 0;
        testsRun      = 0;
        badTests      = 0;
        readsIssued   = 0;
        readsReturned = 0;
        writesSeen    = 0;
    end

    task automatic closeTest();
        if (testErrors == 0) begin
            $display("%0s: pass, %0d checks", curName, testChecks);
        end else begin
            $display("%0s: FAIL, %0d of %0d checks wrong", curName, testErrors, testChecks);
            badTests++;
        end
        testsRun++;
        testChecks = 0;
        testErrors = 0;
    endtask

    // ======================================================================
    // compare on the sampling edge
    // ======================================================================

    always @(posedge clk) begin
        if (!reset) begin
            if (readReq.valid === 1'b1) readsIssued++;
            if (writeReq.valid === 1'b1) writesSeen++;
            if (readResult.valid === 1'b1) readsReturned++;
        end
        if (expActive) begin
            if (expName != curName) begin
                if (curName != '0) closeTest();
                curName = expName;
            end
            testChecks++;
            if (readResult !== expResult) begin
                $display("** Error [%0s] readResult expected valid %0b data %h, actual valid %0b data %h",
                         curName, expResult.valid, expResult.data,
                         readResult.valid, readResult.data);
                testErrors++;
            end
            if (writeDropped !== expDrop) begin
                $display("** Error [%0s] writeDropped expected %0b, actual %0b",
                         curName, expDrop, writeDropped);
                testErrors++;
            end
        end
        if (done && !reported) begin
            if (curName != '0) closeTest();
            failedTests = badTests;
            if (readsIssued != readsReturned) begin
                $display("read results went missing, %0d reads issued but %0d returned",
                         readsIssued, readsReturned);
                failedTests++;
            end
            $display("tests %0d, passing %0d, failing %0d, reads %0d, writes %0d",
                     testsRun, testsRun - badTests, badTests, readsIssued, writesSeen);
            reported = 1'b1;
        end
    end

endmodule

// ==== testbench/multiBankMemoryTb.sv ====
`include "memory_defs.svh"

module multiBankMemoryTb;

    import memPkg::*;

    localparam int NameBits     = 192;
    localparam int ResetCycles  = 16;
    localparam int FillerCycles = 24;
    localparam logic [`MEM_ADDR_WIDTH-1:0] FillerAddr = 11'h6c0; // g1 b1 s1 row 40.

    typedef struct packed {
        logic [NameBits-1:0] name;
        readReqT             rd;
        writeReqT            wr;
        dataT                expData;
        logic                expDrop;
    } vectorT;

    typedef struct packed {
        logic                active;
        logic [NameBits-1:0] name;
        readResultT          result;
        logic                drop;
    } expectT;

    logic                clk;
    logic                reset;
    readReqT             readReq;
    writeReqT            writeReq;
    readResultT          readResult;
    logic                writeDropped;
    logic                expActive;
    logic [NameBits-1:0] expName;
    readResultT          expResult;
    logic                expDrop;
    logic                done;
    logic                reported;
    int                  failedTests;
    vectorT              vecs [$];
    expectT              expQ [$];
    integer              seed;
    int                  cycleCount;
    int                  cycleLimit = 0;

    multiBankMemory u_dut (
        .clk         (clk),
        .reset       (reset),
        .readReq     (readReq),
        .writeReq    (writeReq),
        .readResult  (readResult),
        .writeDropped(writeDropped)
    );

    memoryChecker #(
        .NameBits(NameBits)
    ) u_checker (
        .clk         (clk),
        .reset       (reset),
        .readReq     (readReq),
        .writeReq    (writeReq),
        .readResult  (readResult),
        .writeDropped(writeDropped),
        .expActive   (expActive),
        .expName     (expName),
        .expResult   (expResult),
        .expDrop     (expDrop),
        .done        (done),
        .reported    (reported),
        .failedTests (failedTests)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ======================================================================
    // vectors
    // ======================================================================

    task automatic loadVectors(output logic ok);
        integer              fd;
        string               line;
        int                  n;
        logic [NameBits-1:0] name;
        logic                rv;
        logic                wv;
        logic [10:0]         ra;
        logic [10:0]         wa;
        logic [7:0]          wd;
        logic [7:0]          ed;
        logic                drop;
        vectorT              v;
        ok = 1'b0;
        fd = $fopen("testbench/memoryVectors.txt", "r");
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                name = '0;
                if (line.getc(0) != "#") begin
                    n = $sscanf(line, "%s %h %h %h %h %h %h %h",
                                name, rv, ra, wv, wa, wd, ed, drop);
                    if (n == 8) begin
                        v.name    = name;
                        v.rd      = '{valid: rv, addr: ra};
                        v.wr      = '{valid: wv, addr: wa, data: wd};
                        v.expData = ed;
                        v.expDrop = drop;
                        vecs.push_back(v);
                    end
                end
            end
            $fclose(fd);
            ok = (vecs.size() > 0);
        end
    endtask

    // random writes to unread addresses around one fixed read address.
    task automatic addFiller();
        logic [31:0] r;
        logic [10:0] wa;
        dataT        fillerByte;
        vectorT      v;
        logic        rv;
        logic        wv;
        seed = 32'h9eec;
        r = $random(seed);
        fillerByte = r[7:0];
        v.name    = "randomFiller";
        v.rd      = '0;
        v.wr      = '{valid: 1'b1, addr: FillerAddr, data: fillerByte};
        v.expData = '0;
        v.expDrop = 1'b0;
        vecs.push_back(v);
        for (int k = 0; k < FillerCycles; k++) begin
            r  = $random(seed);
            rv = r[0];
            wv = r[1];
            wa = r[12:2];
            if (r[13]) wa[10:7] = FillerAddr[10:7]; // aim at the read subarray.
            if (wa == FillerAddr) wa[0] = ~wa[0];
            v.rd      = '{valid: rv, addr: FillerAddr};
            v.wr      = '{valid: wv, addr: wa, data: r[21:14]};
            v.expData = rv ? fillerByte : 8'h00;
            v.expDrop = rv && wv && (wa[10:7] == FillerAddr[10:7]);
            vecs.push_back(v);
        end
    endtask

    // drive one request and release the expectation now due.
    task automatic applyVector(input vectorT v, input logic active);
        expectT e;
        readReq  = v.rd;
        writeReq = v.wr;
        e.active = active;
        e.name   = v.name;
        e.result = '{valid: v.rd.valid, data: v.rd.valid ? v.expData : 8'h00};
        e.drop   = v.expDrop;
        expQ.push_back(e);
        if (expQ.size() > `MEM_READ_LATENCY) begin
            e         = expQ.pop_front();
            expActive = e.active;
            expName   = e.name;
            expResult = e.result;
            expDrop   = e.drop;
        end
    endtask

    task automatic runVectors();
        vectorT idle;
        expectT resetIdle;
        idle             = '0;
        resetIdle        = '0;
        resetIdle.active = 1'b1;
        resetIdle.name   = "idleZero";
        // results seen in the first cycles come from reset.
        repeat (`MEM_READ_LATENCY) expQ.push_back(resetIdle);
        repeat (ResetCycles) @(posedge clk);
        #1;
        reset = 1'b0;
        foreach (vecs[i]) begin
            applyVector(vecs[i], 1'b1);
            @(posedge clk);
            #1;
        end
        repeat (`MEM_READ_LATENCY + 1) begin
            applyVector(idle, 1'b0); // drain results in flight.
            @(posedge clk);
            #1;
        end
    endtask

    // ======================================================================
    // run and timeout
    // ======================================================================

    initial begin : watchdog
        cycleCount = 0;
        wait (cycleLimit > 0);
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("run timed out after %0d cycles", cycleCount);
        $display("test failed");
        $finish;
    end

    initial begin : main
        logic ok;
        reset     = 1'b1;
        readReq   = '0;
        writeReq  = '0;
        expActive = 1'b0;
        expName   = '0;
        expResult = '0;
        expDrop   = 1'b0;
        done      = 1'b0;
        loadVectors(ok);
        if (!ok) begin
            $display("vector file testbench/memoryVectors.txt could not be read");
            $display("test failed");
            $finish;
        end else begin
            addFiller();
            cycleLimit = vecs.size() * 2 + ResetCycles + 50;
            runVectors();
            done = 1'b1;
            wait (reported);
            if (failedTests == 0) begin
                $display("test passed");
            end else begin
                $display("test failed");
            end
            $finish;
        end
    end

endmodule

// ==== files.f ====
+incdir+source
source/memPkg.sv
source/subArray.sv
source/memoryBank.sv
source/bankGroup.sv
source/readMerge.sv
source/multiBankMemory.sv
testbench/memoryChecker.sv
testbench/multiBankMemoryTb.sv

// ==== Bender.yml ====
package:
  name: multi_bank_memory

export_include_dirs:
  - source

sources:
  # RTL, in compile order
  - include_dirs:
      - source
    files:
      - source/memPkg.sv
      - source/subArray.sv
      - source/memoryBank.sv
      - source/bankGroup.sv
      - source/readMerge.sv
      - source/multiBankMemory.sv

  # testbench
  - target: test
    include_dirs:
      - source
    files:
      - testbench/memoryChecker.sv
      - testbench/multiBankMemoryTb.sv

// ==== testbench/memoryVectors.txt ====
# test rdValid rdAddr wrValid wrAddr wrData expData expDrop, all hex
# expData is the byte returned for this line's read, expDrop flags this line's write
idleZero 0 000 0 000 00 00 0
idleZero 0 7ff 0 7ff 5a 00 0
idleZero 0 000 0 000 00 00 0
writeThenRead 0 000 1 000 11 00 0
writeThenRead 0 000 1 07f 22 00 0
writeThenRead 0 000 1 0a5 33 00 0
writeThenRead 0 000 1 3ff 44 00 0
writeThenRead 0 000 1 47f 55 00 0
writeThenRead 0 000 1 780 66 00 0
writeThenRead 0 000 1 53c 77 00 0
writeThenRead 1 000 0 000 00 11 0
writeThenRead 1 07f 0 000 00 22 0
writeThenRead 1 0a5 0 000 00 33 0
writeThenRead 1 3ff 0 000 00 44 0
writeThenRead 1 47f 0 000 00 55 0
writeThenRead 1 780 0 000 00 66 0
writeThenRead 1 53c 0 000 00 77 0
parallelPorts 1 000 1 0a6 a1 11 0
parallelPorts 1 07f 1 27f a2 22 0
parallelPorts 1 47f 1 07e a3 55 0
parallelPorts 1 0a6 0 000 00 a1 0
parallelPorts 1 27f 0 000 00 a2 0
parallelPorts 1 07e 0 000 00 a3 0
sameSubarrayConflict 1 000 1 07f ee 11 1
sameSubarrayConflict 1 3ff 1 3ff ef 44 1
sameSubarrayConflict 1 53c 1 500 f0 77 1
sameSubarrayConflict 0 000 0 000 00 00 0
sameSubarrayConflict 1 07f 0 000 00 22 0
sameSubarrayConflict 1 3ff 0 000 00 44 0
backToBack 1 000 0 000 00 11 0
backToBack 1 780 0 000 00 66 0
backToBack 1 3ff 0 000 00 44 0
backToBack 1 47f 0 000 00 55 0
backToBack 1 0a5 0 000 00 33 0
backToBack 1 53c 0 000 00 77 0
backToBack 1 27f 0 000 00 a2 0
